// ==== common/neuron_consts.svh ====
//********************
// sizes and fixed values shared by the core tile RTL and its testbench
// include this file wherever a packet, flit, axon or neuron width is needed
//********************

`ifndef NEURON_CONSTS_SVH
`define NEURON_CONSTS_SVH

// a spike packet is eight flits, least significant flit first
`define PACKET_SIZE 32
`define FLIT_SIZE 4

// tile address fields sit at the bottom of the packet, axon id starts right above them
`define X_ADDR_LEN 8
`define Y_ADDR_LEN 8

`define NUM_AXONS 4
`define AXON_ID_W 2
`define NUM_NEURONS 4
`define NEURON_ID_W 2

// synapse weights and membrane potentials are signed
`define WEIGHT_W 8
`define POTENTIAL_W 16

// firing level and leak rate, the leak removes potential >>> LEAK_SHIFT each timestep
`define THRESHOLD 64
`define LEAK_SHIFT 3

// flit address bits of the clock-crossing FIFO
`define FIFO_DEPTH_LOG2 5

// address of this tile, stamped into every output packet
`define CORE_X 8'd3
`define CORE_Y 8'd5

`endif

// ==== common/neuron_pkg.sv ====
//********************
// types shared by the neuron core tile
// holds the neuron and packetizer state encodings and the data types
// of weights, potentials and packets
//********************

`include "neuron_consts.svh"

package neuron_pkg;

	// states of one leaky integrate-and-fire neuron
	// idle waits for start, integrate applies weights and leak, fire compares to threshold
	typedef enum logic [1:0]
	{
		NEURON_IDLE,
		NEURON_INTEGRATE,
		NEURON_FIRE
	} neuron_state_t;

	// states of the output packetizer
	typedef enum logic
	{
		PACK_IDLE,
		PACK_SCAN
	} pack_state_t;

	// one synapse weight, signed
	typedef logic signed [`WEIGHT_W-1:0] weight_t;

	// membrane potential, signed so that inhibitory weights can pull it below zero
	typedef logic signed [`POTENTIAL_W-1:0] potential_t;

	// a whole spike packet as it leaves the FIFO or the packetizer
	typedef logic [`PACKET_SIZE-1:0] packet_t;

endpackage

// ==== neuron_core_top.f ====
+incdir+common
common/neuron_pkg.sv
spike_interface/flit_fifo.sv
spike_interface/spike_interface.sv
src/lif_neuron.sv
src/spike_packetizer.sv
src/neuron_core_top.sv
test/neuron_core_tb.sv

// ==== spike_interface/flit_fifo.sv ====
//********************
// dual-clock FIFO that takes 4-bit flits on the router clock
// and hands out whole 32-bit packets on the neuron clock
// rd_empty stays high until a full packet of eight flits is stored
//********************

`include "neuron_consts.svh"

module flit_fifo
(
	input  logic                  wr_clk,
	input  logic                  neuron_clk,
	input  logic                  rst_n,
	input  logic                  wr_en,
	input  logic [`FLIT_SIZE-1:0] wr_data,
	output logic                  wr_full,
	input  logic                  rd_req,
	output neuron_pkg::packet_t   rd_data,
	output logic                  rd_empty
);

	localparam int depth = 1 << `FIFO_DEPTH_LOG2;
	localparam int ptr_w = `FIFO_DEPTH_LOG2 + 1;
	localparam int flits = `PACKET_SIZE / `FLIT_SIZE;
	localparam int flit_sel_w = $clog2(flits);
	// the read pointer counts whole packets, so it has fewer bits than the write pointer
	localparam int pkt_ptr_w = ptr_w - flit_sel_w;

	logic [`FLIT_SIZE-1:0] mem [depth];

	logic                 wr_rst_q;
	logic                 wr_rst_n;
	logic [ptr_w-1:0]     wr_bin;
	logic [ptr_w-1:0]     wr_bin_next;
	logic [ptr_w-1:0]     wr_gray;
	logic [ptr_w-1:0]     wr_gray_s1;
	logic [ptr_w-1:0]     wr_gray_s2;
	logic [pkt_ptr_w-1:0] rd_pkt_bin;
	logic [pkt_ptr_w-1:0] rd_pkt_bin_next;
	logic [pkt_ptr_w-1:0] rd_pkt_gray;
	logic [pkt_ptr_w-1:0] rd_gray_s1;
	logic [pkt_ptr_w-1:0] rd_gray_s2;
	logic [ptr_w-1:0]     wr_side_rd_bin;
	logic [ptr_w-1:0]     wr_count;
	logic [ptr_w-1:0]     rd_side_wr_bin;
	logic [ptr_w-1:0]     rd_count;

	function automatic logic [ptr_w-1:0] gray_to_bin(input logic [ptr_w-1:0] g);
		logic [ptr_w-1:0] b;
		b[ptr_w-1] = g[ptr_w-1];
		for (int i = ptr_w - 2; i >= 0; i--)
		begin
			b[i] = b[i+1] ^ g[i];
		end
		return b;
	endfunction

	// rst_n asserts at once in the router domain but releases on wr_clk
	always_ff @(posedge wr_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_rst_q <= 1'b0;
			wr_rst_n <= 1'b0;
		end
		else
		begin
			wr_rst_q <= 1'b1;
			wr_rst_n <= wr_rst_q;
		end
	end

	// write side, one flit per accepted strobe, flits are dropped while full
	assign wr_bin_next = wr_bin + 1'b1;

	always_ff @(posedge wr_clk or negedge wr_rst_n)
	begin
		if (!wr_rst_n)
		begin
			wr_bin <= '0;
			wr_gray <= '0;
			rd_gray_s1 <= '0;
			rd_gray_s2 <= '0;
		end
		else
		begin
			rd_gray_s1 <= rd_pkt_gray;
			rd_gray_s2 <= rd_gray_s1;
			if (wr_en && !wr_full)
			begin
				wr_bin <= wr_bin_next;
				wr_gray <= wr_bin_next ^ (wr_bin_next >> 1);
			end
		end
	end

	always_ff @(posedge wr_clk)
	begin
		if (wr_en && !wr_full)
			mem[wr_bin[`FIFO_DEPTH_LOG2-1:0]] <= wr_data;
	end

	// packet pointer turned back into a flit count, the low flit bits are always zero
	assign wr_side_rd_bin = gray_to_bin(ptr_w'(rd_gray_s2));
	assign wr_count = wr_bin - {wr_side_rd_bin[pkt_ptr_w-1:0], {flit_sel_w{1'b0}}};
	assign wr_full = (wr_count == ptr_w'(depth));

	// read side sees the write pointer two neuron_clk edges late
	assign rd_side_wr_bin = gray_to_bin(wr_gray_s2);
	assign rd_count = rd_side_wr_bin - {rd_pkt_bin, {flit_sel_w{1'b0}}};
	assign rd_empty = (rd_count < ptr_w'(flits));
	assign rd_pkt_bin_next = rd_pkt_bin + 1'b1;

	always_ff @(posedge neuron_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			wr_gray_s1 <= '0;
			wr_gray_s2 <= '0;
			rd_pkt_bin <= '0;
			rd_pkt_gray <= '0;
		end
		else
		begin
			wr_gray_s1 <= wr_gray;
			wr_gray_s2 <= wr_gray_s1;
			if (rd_req && !rd_empty)
			begin
				rd_pkt_bin <= rd_pkt_bin_next;
				rd_pkt_gray <= rd_pkt_bin_next ^ (rd_pkt_bin_next >> 1);
			end
		end
	end

	// eight flits become one packet, the oldest flit lands in the low nibble
	always_ff @(posedge neuron_clk)
	begin
		if (rd_req && !rd_empty)
		begin
			for (int i = 0; i < flits; i++)
			begin
				rd_data[i*`FLIT_SIZE +: `FLIT_SIZE] <=
					mem[{rd_pkt_bin[pkt_ptr_w-2:0], flit_sel_w'(i)}];
			end
		end
	end

endmodule

// ==== spike_interface/spike_interface.sv ====
//********************
// receives spike packets from the router and keeps a sticky
// per-axon spike vector for the neurons of this tile
// the vector is cleared one cycle after every start pulse
//********************

`include "neuron_consts.svh"

module spike_interface
(
	input  logic                  router_clk,
	input  logic                  neuron_clk,
	input  logic                  rst_n,
	input  logic                  write_en,
	input  logic                  start,
	input  logic [`FLIT_SIZE-1:0] data_in,
	output logic [`NUM_AXONS-1:0] spike,
	output logic                  neuron_full
);

	import neuron_pkg::*;

	packet_t               packet;
	logic                  fifo_empty;
	logic                  rd_req;
	logic                  write_spike;
	logic                  clear_spike;
	logic [`AXON_ID_W-1:0] axon_id;

	flit_fifo u_flit_fifo
	(
		.wr_clk     (router_clk),
		.neuron_clk (neuron_clk),
		.rst_n      (rst_n),
		.wr_en      (write_en),
		.wr_data    (data_in),
		.wr_full    (neuron_full),
		.rd_req     (rd_req),
		.rd_data    (packet),
		.rd_empty   (fifo_empty)
	);

	// keep draining as long as a whole packet waits
	assign rd_req = ~fifo_empty;

	// axon id sits just above the x and y address fields
	assign axon_id = packet[`X_ADDR_LEN + `Y_ADDR_LEN +: `AXON_ID_W];

	always_ff @(posedge neuron_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			write_spike <= 1'b0;
			clear_spike <= 1'b0;
			spike <= '0;
		end
		else
		begin
			// FIFO data shows up one cycle after the read request
			write_spike <= rd_req;
			clear_spike <= start;
			// the neurons sampled the vector at start, so the clear takes priority
			if (clear_spike)
				spike <= '0;
			else if (write_spike)
				spike[axon_id] <= 1'b1;
		end
	end

endmodule

// ==== src/lif_neuron.sv ====
//********************
// one leaky integrate-and-fire neuron with its own synapse weights
// a start pulse runs sample, integrate with leak and threshold check,
// fire pulses two cycles after start
//********************

`include "neuron_consts.svh"

module lif_neuron
(
	input  logic                  neuron_clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic [`NUM_AXONS-1:0] spike,
	input  logic                  cfg_we,
	input  logic [`AXON_ID_W-1:0] cfg_axon,
	input  neuron_pkg::weight_t   cfg_weight,
	output logic                  fire
);

	import neuron_pkg::*;

	neuron_state_t         state;
	weight_t               weights [`NUM_AXONS];
	logic [`NUM_AXONS-1:0] spike_q;
	potential_t            potential;
	potential_t            syn_sum;
	potential_t            next_pot;

	// sum of the weights of the sampled axons, each weight sign extended
	always_comb
	begin
		syn_sum = '0;
		for (int i = 0; i < `NUM_AXONS; i++)
		begin
			if (spike_q[i])
				syn_sum = syn_sum + potential_t'(weights[i]);
		end
	end

	// leak is taken from the old potential, arithmetic shift keeps the sign
	assign next_pot = potential + syn_sum - (potential >>> `LEAK_SHIFT);

	always_ff @(posedge neuron_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			for (int i = 0; i < `NUM_AXONS; i++)
			begin
				weights[i] <= '0;
			end
		end
		else if (cfg_we)
			weights[cfg_axon] <= cfg_weight;
	end

	always_ff @(posedge neuron_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= NEURON_IDLE;
			spike_q <= '0;
			potential <= '0;
			fire <= 1'b0;
		end
		else
		begin
			fire <= 1'b0;
			case (state)
				NEURON_IDLE:
				begin
					// spikes present on the start edge belong to this timestep
					if (start)
					begin
						spike_q <= spike;
						state <= NEURON_INTEGRATE;
					end
				end
				NEURON_INTEGRATE:
				begin
					potential <= next_pot;
					state <= NEURON_FIRE;
				end
				NEURON_FIRE:
				begin
					if (potential >= potential_t'(`THRESHOLD))
					begin
						fire <= 1'b1;
						potential <= '0;
					end
					state <= NEURON_IDLE;
				end
				default:
					state <= NEURON_IDLE;
			endcase
		end
	end

endmodule

// ==== src/neuron_core_top.sv ====
//********************
// top level of one neuromorphic core tile
// router flits come in through the spike interface, the neuron array
// integrates on every start pulse and fired neurons leave as packets
//********************

`include "neuron_consts.svh"

module neuron_core_top
(
	input  logic                    router_clk,
	input  logic                    neuron_clk,
	input  logic                    rst_n,
	input  logic                    write_en,
	input  logic                    start,
	input  logic                    cfg_we,
	input  logic [`FLIT_SIZE-1:0]   data_in,
	input  logic [`NEURON_ID_W-1:0] cfg_neuron,
	input  logic [`AXON_ID_W-1:0]   cfg_axon,
	input  neuron_pkg::weight_t     cfg_weight,
	output logic                    neuron_full,
	output logic                    out_valid,
	output neuron_pkg::packet_t     out_packet
);

	logic [`NUM_AXONS-1:0]   spike;
	logic [`NUM_NEURONS-1:0] neuron_we;
	logic [`NUM_NEURONS-1:0] fire;

	spike_interface u_spike_interface
	(
		.router_clk  (router_clk),
		.neuron_clk  (neuron_clk),
		.rst_n       (rst_n),
		.write_en    (write_en),
		.start       (start),
		.data_in     (data_in),
		.spike       (spike),
		.neuron_full (neuron_full)
	);

	// a weight write reaches only the neuron named by cfg_neuron
	always_comb
	begin
		neuron_we = '0;
		neuron_we[cfg_neuron] = cfg_we;
	end

	// every neuron sees the same spike vector and the same start pulse
	for (genvar n = 0; n < `NUM_NEURONS; n++)
	begin : g_neuron
		lif_neuron u_lif_neuron
		(
			.neuron_clk (neuron_clk),
			.rst_n      (rst_n),
			.start      (start),
			.spike      (spike),
			.cfg_we     (neuron_we[n]),
			.cfg_axon   (cfg_axon),
			.cfg_weight (cfg_weight),
			.fire       (fire[n])
		);
	end

	spike_packetizer u_spike_packetizer
	(
		.neuron_clk (neuron_clk),
		.rst_n      (rst_n),
		.fire       (fire),
		.out_valid  (out_valid),
		.out_packet (out_packet)
	);

endmodule

// ==== src/spike_packetizer.sv ====
//********************
// turns the fire pulses of one timestep into output packets
// one packet per fired neuron, lowest neuron id first, on back to back cycles
//********************

`include "neuron_consts.svh"

module spike_packetizer
(
	input  logic                    neuron_clk,
	input  logic                    rst_n,
	input  logic [`NUM_NEURONS-1:0] fire,
	output logic                    out_valid,
	output neuron_pkg::packet_t     out_packet
);

	import neuron_pkg::*;

	pack_state_t             state;
	logic [`NUM_NEURONS-1:0] pending;
	logic [`NUM_NEURONS-1:0] pending_next;
	logic [`NEURON_ID_W-1:0] low_id;

	// walk down from the top so that the lowest set bit is the one kept
	always_comb
	begin
		low_id = '0;
		for (int i = `NUM_NEURONS - 1; i >= 0; i--)
		begin
			if (pending[i])
				low_id = `NEURON_ID_W'(i);
		end
	end

	// drop the neuron that is being sent this cycle
	assign pending_next = pending & ~(`NUM_NEURONS'(1) << low_id);

	// outputs follow the scan state directly, so the first packet
	// leaves in the cycle right after the fire vector was latched
	assign out_valid = (state == PACK_SCAN);

	always_comb
	begin
		out_packet = '0;
		out_packet[`X_ADDR_LEN-1:0] = `CORE_X;
		out_packet[`X_ADDR_LEN +: `Y_ADDR_LEN] = `CORE_Y;
		out_packet[`X_ADDR_LEN + `Y_ADDR_LEN +: `NEURON_ID_W] = low_id;
	end

	always_ff @(posedge neuron_clk or negedge rst_n)
	begin
		if (!rst_n)
		begin
			state <= PACK_IDLE;
			pending <= '0;
		end
		else
		begin
			case (state)
				PACK_IDLE:
				begin
					// a timestep with no firing leaves the packetizer idle
					if (|fire)
					begin
						pending <= fire;
						state <= PACK_SCAN;
					end
				end
				PACK_SCAN:
				begin
					pending <= pending_next;
					if (pending_next == '0)
						state <= PACK_IDLE;
				end
				default:
					state <= PACK_IDLE;
			endcase
		end
	end

endmodule

// ==== test/neuron_core_tb.sv ====
//********************
// testbench for the neuron core tile
// writes spike packets as router flits, configures weights, pulses start
// and checks every output packet against a reference model of the neurons
// run it as the top module together with the file list
//********************

`include "neuron_consts.svh"

module neuron_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	import neuron_pkg::*;

	// spikes need this many neuron_clk cycles to reach the spike vector
	localparam int settle_cycles = 12;
	// the last output packet of a timestep lands within this many cycles of start
	localparam int out_window = `NUM_NEURONS + 3;
	// router_clk cycles that neuron_full may stay high
	localparam int full_timeout = 200;

	logic                    router_clk;
	logic                    neuron_clk;
	logic                    rst_n;
	logic                    write_en;
	logic                    start;
	logic                    cfg_we;
	logic [`FLIT_SIZE-1:0]   data_in;
	logic [`NEURON_ID_W-1:0] cfg_neuron;
	logic [`AXON_ID_W-1:0]   cfg_axon;
	weight_t                 cfg_weight;
	logic                    neuron_full;
	logic                    out_valid;
	packet_t                 out_packet;

	// state of the reference model, mirrors what the neurons should hold
	logic [31:0] lfsr;
	potential_t  model_pot [`NUM_NEURONS];
	weight_t     model_w [`NUM_NEURONS][`NUM_AXONS];
	packet_t     exp_q [$];
	packet_t     exp_pkt;
	int          rx_count;
	int          exp_count;
	int          cycle_no;
	int          last_valid_cycle;

	neuron_core_top i_dut
	(
		.router_clk  (router_clk),
		.neuron_clk  (neuron_clk),
		.rst_n       (rst_n),
		.write_en    (write_en),
		.start       (start),
		.cfg_we      (cfg_we),
		.data_in     (data_in),
		.cfg_neuron  (cfg_neuron),
		.cfg_axon    (cfg_axon),
		.cfg_weight  (cfg_weight),
		.neuron_full (neuron_full),
		.out_valid   (out_valid),
		.out_packet  (out_packet)
	);

	initial
	begin
		neuron_clk = 1'b0;
		forever #10 neuron_clk = ~neuron_clk;
	end

	initial
	begin
		router_clk = 1'b0;
		forever #7 router_clk = ~router_clk;
	end

	// fibonacci LFSR, taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		logic feedback;
		feedback = s[31] ^ s[21] ^ s[1] ^ s[0];
		return {s[30:0], feedback};
	endfunction

	// one LFSR step per returned bit
	task automatic take_bits(input int count, output logic [31:0] value);
		value = '0;
		for (int i = 0; i < count; i++)
		begin
			lfsr = lfsr_step(lfsr);
			value = {value[30:0], lfsr[0]};
		end
	endtask

	// one timestep of the whole neuron array
	// potential plus active weights minus the leak, then threshold and reset
	function automatic logic [`NUM_NEURONS-1:0] model_timestep
	(
		input  potential_t            pot_in [`NUM_NEURONS],
		input  weight_t               w [`NUM_NEURONS][`NUM_AXONS],
		input  logic [`NUM_AXONS-1:0] spikes,
		output potential_t            pot_out [`NUM_NEURONS]
	);
		logic [`NUM_NEURONS-1:0] fired;
		int drive;
		int level;
		fired = '0;
		for (int n = 0; n < `NUM_NEURONS; n++)
		begin
			drive = 0;
			for (int a = 0; a < `NUM_AXONS; a++)
			begin
				if (spikes[a])
					drive = drive + int'(w[n][a]);
			end
			level = int'(pot_in[n]) + drive - (int'(pot_in[n]) >>> `LEAK_SHIFT);
			if (level >= `THRESHOLD)
			begin
				fired[n] = 1'b1;
				pot_out[n] = '0;
			end
			else
				pot_out[n] = potential_t'(level);
		end
		return fired;
	endfunction

	// output packet layout, x in 7:0, y in 15:8, neuron id in 17:16
	function automatic packet_t expected_packet(input int id);
		packet_t pkt;
		pkt = '0;
		pkt[7:0] = `CORE_X;
		pkt[15:8] = `CORE_Y;
		pkt[17:16] = id[1:0];
		return pkt;
	endfunction

	task automatic abort_run;
		$display("Simulation failed");
		$fatal(1, "run stopped at the first error");
	endtask

	task automatic check_packet(input packet_t actual, input packet_t expected);
		if (actual !== expected)
		begin
			$display("** Error at %0d ns: out_packet is %h, expected %h",
				$time, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_count(input string name, input int actual, input int expected);
		if (actual != expected)
		begin
			$display("** Error at %0d ns: %s is %0d, expected %0d",
				$time, name, actual, expected);
			abort_run();
		end
	endtask

	task automatic check_flag(input string name, input logic actual, input logic expected);
		if (actual !== expected)
		begin
			$display("** Error at %0d ns: %s is %b, expected %b",
				$time, name, actual, expected);
			abort_run();
		end
	endtask

	task automatic wait_neuron_cycles(input int count);
		for (int i = 0; i < count; i++)
		begin
			@(posedge neuron_clk);
		end
	endtask

	// looks at neuron_full mid-cycle, where it cannot change
	task automatic wait_full_clear;
		int waited;
		waited = 0;
		@(negedge router_clk);
		while (neuron_full && waited < full_timeout)
		begin
			@(negedge router_clk);
			waited++;
		end
		if (neuron_full)
		begin
			$display("neuron_full stayed high for %0d router_clk cycles", full_timeout);
			abort_run();
		end
	endtask

	// every other router cycle, so neuron_full is seen after the previous flit landed
	task automatic write_flit(input logic [`FLIT_SIZE-1:0] flit);
		wait_full_clear();
		@(posedge router_clk);
		data_in <= flit;
		write_en <= 1'b1;
		@(posedge router_clk);
		write_en <= 1'b0;
	endtask

	// the upper bits carry random filler, only the axon id field matters
	task automatic send_packet(input int axon);
		logic [31:0] r;
		packet_t pkt;
		take_bits(32, r);
		pkt = r;
		pkt[7:0] = `CORE_X;
		pkt[15:8] = `CORE_Y;
		pkt[17:16] = axon[1:0];
		for (int i = 0; i < `PACKET_SIZE / `FLIT_SIZE; i++)
		begin
			write_flit(pkt[i*`FLIT_SIZE +: `FLIT_SIZE]);
		end
	endtask

	task automatic set_weight(input int neuron, input int axon, input weight_t w);
		@(posedge neuron_clk);
		cfg_we <= 1'b1;
		cfg_neuron <= `NEURON_ID_W'(neuron);
		cfg_axon <= `AXON_ID_W'(axon);
		cfg_weight <= w;
		@(posedge neuron_clk);
		cfg_we <= 1'b0;
		model_w[neuron][axon] = w;
	endtask

	// lets the spikes settle, predicts the outputs, pulses start and
	// counts the packets of the whole output window
	task automatic run_timestep(input logic [`NUM_AXONS-1:0] spikes);
		potential_t next_pot [`NUM_NEURONS];
		logic [`NUM_NEURONS-1:0] fire_exp;
		wait_neuron_cycles(settle_cycles);
		fire_exp = model_timestep(model_pot, model_w, spikes, next_pot);
		model_pot = next_pot;
		exp_count = 0;
		for (int n = 0; n < `NUM_NEURONS; n++)
		begin
			if (fire_exp[n])
			begin
				exp_q.push_back(expected_packet(n));
				exp_count++;
			end
		end
		rx_count = 0;
		@(posedge neuron_clk);
		start <= 1'b1;
		@(posedge neuron_clk);
		start <= 1'b0;
		// all packets of this timestep are out by the end of the window
		wait_neuron_cycles(out_window);
		check_count("out_valid count", rx_count, exp_count);
	endtask

	// compares every out_valid with the head of the expected list
	// a timestep's packets must come on back to back cycles
	always @(negedge neuron_clk)
	begin
		cycle_no++;
		if (rst_n && out_valid)
		begin
			if (exp_q.size() == 0)
			begin
				$display("out_valid rose at %0d ns with no packet expected", $time);
				abort_run();
			end
			else
			begin
				exp_pkt = exp_q.pop_front();
				check_packet(out_packet, exp_pkt);
				if (rx_count > 0 && cycle_no != last_valid_cycle + 1)
				begin
					$display("output packets of one timestep were not on consecutive cycles");
					abort_run();
				end
				last_valid_cycle = cycle_no;
				rx_count++;
			end
		end
	end

	initial
	begin
		logic [31:0] r;
		logic [`NUM_AXONS-1:0] spikes;
		int packets;
		rst_n = 1'b0;
		write_en = 1'b0;
		start = 1'b0;
		cfg_we = 1'b0;
		data_in = '0;
		cfg_neuron = '0;
		cfg_axon = '0;
		cfg_weight = '0;
		lfsr = 32'h7aa1ca53;
		cycle_no = 0;
		last_valid_cycle = 0;
		rx_count = 0;
		exp_count = 0;
		for (int n = 0; n < `NUM_NEURONS; n++)
		begin
			model_pot[n] = '0;
			for (int a = 0; a < `NUM_AXONS; a++)
			begin
				model_w[n][a] = '0;
			end
		end
		wait_neuron_cycles(2);
		rst_n <= 1'b1;

		// reset state, nothing comes out and the FIFO is not full
		wait_neuron_cycles(10);
		@(negedge router_clk);
		check_flag("neuron_full", neuron_full, 1'b0);
		run_timestep('0);

		// a single neuron fires from axon 2
		set_weight(1, 2, weight_t'(80));
		send_packet(2);
		run_timestep(4'b0100);

		// the previous spike must be gone, the model sees an empty set
		run_timestep('0);

		// three neurons fire together and leave in id order
		set_weight(0, 0, weight_t'(100));
		set_weight(2, 0, weight_t'(100));
		set_weight(3, 0, weight_t'(100));
		send_packet(0);
		run_timestep(4'b0001);

		// random weights between -64 and 63, random spike sets
		for (int n = 0; n < `NUM_NEURONS; n++)
		begin
			for (int a = 0; a < `NUM_AXONS; a++)
			begin
				take_bits(7, r);
				set_weight(n, a, weight_t'({r[6], r[6:0]}));
			end
		end
		for (int t = 0; t < 30; t++)
		begin
			spikes = '0;
			take_bits(2, r);
			packets = int'(r[1:0]);
			for (int k = 0; k < packets; k++)
			begin
				take_bits(2, r);
				send_packet(int'(r[1:0]));
				spikes[r[1:0]] = 1'b1;
			end
			run_timestep(spikes);
		end

		// long burst, the writer holds off whenever neuron_full is high
		spikes = '0;
		for (int k = 0; k < 8; k++)
		begin
			take_bits(2, r);
			send_packet(int'(r[1:0]));
			spikes[r[1:0]] = 1'b1;
		end
		wait_full_clear();
		run_timestep(spikes);

		// a late stray packet would still reach the checker here
		wait_neuron_cycles(out_window);
		$display("Simulation passed");
		$finish;
	end

endmodule
